//--- filelist.f
wiscPkg.sv
cla16.sv
instrDecode.sv
branchJumpAlu.sv
writeBack.sv
axiLiteSlave.sv
i2UnitTop.sv
i2Unit_props.sv
i2UnitTb.sv

//--- i2UnitTb.sv
`timescale 1ns/1ps
module i2UnitTb;
	import wiscPkg::*;

	localparam int clkPeriod = 8;
	localparam int hostOps = 24;
	localparam int branchOps = 40;
	localparam int loadOps = 24;
	localparam int jumpOps = 32;
	localparam int illegalOps = 8;
	localparam int stallOps = 8;
	// reset check and response checks counted as a few extra operations
	localparam int totalOps = hostOps + branchOps + loadOps + jumpOps + illegalOps + stallOps + 6;
	// an instruction with setup, polling and a full state readback stays well below this
	localparam int cyclesPerOp = 150;

	logic clk;
	logic arstN;
	logic [axiAddrW-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [axiDataW-1:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [axiAddrW-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [axiDataW-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// reference model of the architectural state
	logic [dataW-1:0] mRegs [regCount];
	logic [dataW-1:0] mPc;
	logic mOvf;
	logic mIll;
	logic [31:0] lcgState;
	string curTest;
	int checks;
	int errors;
	int testsRun;
	int checksAtStart;
	int errorsAtStart;

	i2UnitTop i_dut (
		.clk(clk),
		.arstN(arstN),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// stops a hung handshake or a stuck busy bit
	initial begin
		#(totalOps * cyclesPerOp * clkPeriod);
		$display("watchdog expired: run did not finish within %0d cycles",
			totalOps * cyclesPerOp);
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// random data biased to zero and the sign boundaries
	function automatic logic [15:0] pickData();
		logic [31:0] r;
		r = nextRand();
		case (r[31:29])
			3'd0: return 16'h0000;
			3'd1: return 16'h7FFF - 16'(r[27:24]);
			3'd2: return 16'h8000 + 16'(r[27:24]);
			3'd3: return 16'hFFFF;
			3'd4: return 16'h7FFE;
			default: return r[23:8];
		endcase
	endfunction

	function automatic logic addOvf(input logic [15:0] a, input logic [15:0] b);
		logic [15:0] s;
		s = a + b;
		// same operand signs and a different result sign
		return (a[15] == b[15]) && (s[15] != a[15]);
	endfunction

	function automatic logic isLegal(input logic [4:0] op);
		case (op)
			opBeqz, opBnez, opBltz, opBgez, opJr, opJalr, opLbi, opSlbi: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	task automatic checkVal(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("error %s %s: expected %h actual %h", curTest, what, exp, act);
		end
	endtask

	task automatic startTest(input string name);
		curTest = name;
		checksAtStart = checks;
		errorsAtStart = errors;
	endtask

	task automatic endTest();
		testsRun++;
		$display("test %s done: %0d checks, %0d errors", curTest,
			checks - checksAtStart, errors - errorsAtStart);
	endtask

	// ready is looked at on the falling edge
	// the transfer lands on the next rising edge
	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
			output logic [1:0] resp, output int waits);
		waits = 0;
		awaddr = addr;
		wdata = data;
		wstrb = 4'hF;
		awvalid = 1'b1;
		wvalid = 1'b1;
		do begin
			@(negedge clk);
			waits++;
		end while (!(awready && wready));
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid = 1'b0;
		do begin
			@(negedge clk);
		end while (!bvalid);
		resp = bresp;
		// bready comes a cycle late so bvalid has to hold
		@(posedge clk);
		#1;
		bready = 1'b1;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		araddr = addr;
		arvalid = 1'b1;
		do begin
			@(negedge clk);
		end while (!arready);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		do begin
			@(negedge clk);
		end while (!rvalid);
		data = rdata;
		resp = rresp;
		// rready comes a cycle late so rvalid has to hold
		@(posedge clk);
		#1;
		rready = 1'b1;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	// target msb set means the PC
	task automatic hostWrite(input logic [3:0] target, input logic [15:0] val, output int waits);
		logic [7:0] addr;
		logic [1:0] resp;
		addr = target[3] ? pcAddr : regBase + {3'b000, target[2:0], 2'b00};
		axiWrite(addr, {16'h0000, val}, resp, waits);
		checkVal("host bresp", respOkay, resp);
		if (target[3]) begin
			mPc = val;
		end else begin
			mRegs[target[2:0]] = val;
		end
	endtask

	task automatic readCheck(input logic [7:0] addr, input logic [31:0] exp, input string what);
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(addr, data, resp);
		checkVal({what, " rresp"}, respOkay, resp);
		checkVal(what, exp, data);
	endtask

	task automatic checkState();
		for (int i = 0; i < regCount; i++) begin
			readCheck(regBase + 8'(4 * i), {16'h0000, mRegs[i]}, $sformatf("r%0d", i));
		end
		readCheck(pcAddr, {16'h0000, mPc}, "pc");
	endtask

	task automatic modelExec(input logic [4:0] op, input logic [2:0] rs, input logic [7:0] imm);
		logic [15:0] sext;
		logic [15:0] seq;
		logic [15:0] rsv;
		logic take;
		sext = {{8{imm[7]}}, imm};
		seq = mPc + 16'd2;
		rsv = mRegs[rs];
		take = (op == opBeqz && rsv == 16'h0000) || (op == opBnez && rsv != 16'h0000)
			|| (op == opBltz && rsv[15]) || (op == opBgez && !rsv[15]);
		mIll = 1'b0;
		case (op)
			opBeqz, opBnez, opBltz, opBgez: begin
				mOvf = take ? addOvf(seq, sext) : addOvf(mPc, 16'd2);
				mPc = take ? seq + sext : seq;
			end
			opJr, opJalr: begin
				// target uses Rs from before the link even when Rs is R7
				mOvf = addOvf(rsv, sext);
				mPc = rsv + sext;
				if (op == opJalr) begin
					mRegs[7] = seq;
				end
			end
			opLbi, opSlbi: begin
				mRegs[rs] = (op == opLbi) ? sext : {rsv[7:0], imm};
				mOvf = addOvf(mPc, 16'd2);
				mPc = seq;
			end
			default: begin
				mIll = 1'b1;
				mOvf = 1'b0;
			end
		endcase
	endtask

	task automatic issueInstr(input logic [4:0] op, input logic [2:0] rs, input logic [7:0] imm);
		logic [1:0] resp;
		int waits;
		axiWrite(instrAddr, {16'h0000, op, rs, imm}, resp, waits);
		checkVal("instr bresp", respOkay, resp);
		modelExec(op, rs, imm);
	endtask

	// polls status until busy clears, then checks the flags
	task automatic waitIdle();
		logic [31:0] status;
		logic [1:0] resp;
		int polls;
		polls = 1;
		axiRead(statusAddr, status, resp);
		while (status[busyBit] && polls < 20) begin
			axiRead(statusAddr, status, resp);
			polls++;
		end
		if (status[busyBit]) begin
			errors++;
			$display("error %s: busy still set after %0d status reads", curTest, polls);
		end
		checkVal("ovf", mOvf, status[ovfBit]);
		checkVal("illegal", mIll, status[illegalBit]);
	endtask

	task automatic runInstr(input logic [4:0] op, input logic [2:0] rs, input logic [7:0] imm);
		issueInstr(op, rs, imm);
		waitIdle();
	endtask

	// random Rs value and PC ahead of an instruction
	task automatic setupOperands(input logic [2:0] rs);
		int waits;
		hostWrite({1'b0, rs}, pickData(), waits);
		hostWrite(targetPc, pickData(), waits);
	endtask

	initial begin
		logic [31:0] r;
		logic [4:0] op;
		logic [1:0] resp;
		logic [31:0] data;
		int waits;
		lcgState = 32'h7945_2e3c;
		checks = 0;
		errors = 0;
		testsRun = 0;
		arstN = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		mPc = '0;
		mOvf = 1'b0;
		mIll = 1'b0;
		for (int i = 0; i < regCount; i++) begin
			mRegs[i] = '0;
		end
		repeat (5) @(posedge clk);
		#1;
		arstN = 1'b1;

		startTest("resetValues");
		checkState();
		readCheck(statusAddr, 32'h0, "status");
		endTest();

		startTest("hostReadBack");
		for (int i = 0; i < hostOps; i++) begin
			r = nextRand();
			hostWrite((r[31:28] == 4'hF) ? targetPc : {1'b0, r[26:24]}, pickData(), waits);
		end
		checkState();
		endTest();

		startTest("branch");
		for (int i = 0; i < branchOps; i++) begin
			r = nextRand();
			setupOperands(r[31:29]);
			runInstr({3'b011, r[28:27]}, r[31:29], r[23:16]);
			checkState();
		end
		endTest();

		startTest("loadImm");
		for (int i = 0; i < loadOps; i++) begin
			r = nextRand();
			setupOperands(r[31:29]);
			runInstr(r[28] ? opLbi : opSlbi, r[31:29], r[23:16]);
			checkState();
		end
		endTest();

		startTest("jump");
		for (int i = 0; i < jumpOps; i++) begin
			r = nextRand();
			setupOperands(r[31:29]);
			runInstr(r[28] ? opJalr : opJr, r[31:29], r[23:16]);
			checkState();
		end
		endTest();

		startTest("illegalOp");
		for (int i = 0; i < illegalOps; i++) begin
			r = nextRand();
			op = r[20:16];
			while (isLegal(op)) begin
				r = nextRand();
				op = r[20:16];
			end
			setupOperands(r[31:29]);
			runInstr(op, r[31:29], r[15:8]);
			checkState();
		end
		endTest();

		startTest("slaveError");
		axiWrite(8'h2C, 32'h1234, resp, waits);
		checkVal("unmapped bresp", respSlvErr, resp);
		axiWrite(8'hC0, 32'h5678, resp, waits);
		checkVal("high bresp", respSlvErr, resp);
		axiWrite(statusAddr, 32'h7, resp, waits);
		checkVal("status bresp", respSlvErr, resp);
		axiRead(instrAddr, data, resp);
		checkVal("instr rresp", respSlvErr, resp);
		axiRead(8'h2C, data, resp);
		checkVal("unmapped rresp", respSlvErr, resp);
		axiRead(8'h22, data, resp);
		checkVal("misaligned rresp", respSlvErr, resp);
		// the status write must not touch the flags
		readCheck(statusAddr, {29'h0, mIll, mOvf, 1'b0}, "status");
		checkState();
		endTest();

		startTest("stalledWrite");
		for (int i = 0; i < stallOps; i++) begin
			r = nextRand();
			setupOperands(r[31:29]);
			op = r[28] ? {3'b011, r[27:26]} : (r[27] ? opJalr : opSlbi);
			issueInstr(op, r[31:29], r[23:16]);
			// lands after commit so the model applies it second
			hostWrite({1'b0, r[14:12]}, pickData(), waits);
			checkVal("write stalled", 32'h1, 32'(waits > 2));
			waitIdle();
			checkState();
		end
		endTest();

		startTest("assertions");
		checkVal("assertion failures", 32'h0, 32'(i_dut.iProps.assertFails));
		endTest();

		$display("summary: %0d tests, %0d checks, %0d errors", testsRun, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- i2Unit_props.sv
`timescale 1ns/1ps
module i2UnitProps (
	input logic clk,
	input logic arstN,
	input logic awvalid,
	input logic wvalid,
	input logic awready,
	input logic bvalid,
	input logic bready,
	input logic rvalid,
	input logic rready,
	input logic launch,
	input logic busy,
	input logic exValid
);

	// number of assertion failures so far
	int assertFails = 0;

	// responses stay up until taken
	bHold: assert property (@(posedge clk) disable iff (!arstN) bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			assertFails++;
		end
	rHold: assert property (@(posedge clk) disable iff (!arstN) rvalid && !rready |=> rvalid)
		else begin
			$error("rvalid dropped before rready");
			assertFails++;
		end

	// no AW/W transfer while an instruction is in flight
	noWrBusy: assert property (@(posedge clk) disable iff (!arstN)
		awready && awvalid && wvalid |-> !busy)
		else begin
			$error("host write accepted while busy");
			assertFails++;
		end

	// commit lands on the third edge after the AW/W handshake
	commitTime: assert property (@(posedge clk) disable iff (!arstN) launch |-> ##2 exValid)
		else begin
			$error("commit not two cycles after launch");
			assertFails++;
		end
	noStrayCommit: assert property (@(posedge clk) disable iff (!arstN)
		exValid |-> $past(launch, 2))
		else begin
			$error("commit without a launch");
			assertFails++;
		end
	busySpan: assert property (@(posedge clk) disable iff (!arstN)
		launch |=> busy ##1 busy ##1 !busy)
		else begin
			$error("busy window does not span launch to commit");
			assertFails++;
		end

endmodule

// slave and writeBack signals meet at the top level
bind i2UnitTop i2UnitProps iProps (
	.clk(clk),
	.arstN(arstN),
	.awvalid(awvalid),
	.wvalid(wvalid),
	.awready(awready),
	.bvalid(bvalid),
	.bready(bready),
	.rvalid(rvalid),
	.rready(rready),
	.launch(launch),
	.busy(statusBits[wiscPkg::busyBit]),
	.exValid(exValid)
);

//--- i2UnitTop.sv
`timescale 1ns/1ps
module i2UnitTop (
	input logic clk,
	input logic arstN,
	input logic [wiscPkg::axiAddrW-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [wiscPkg::axiDataW-1:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [wiscPkg::axiAddrW-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [wiscPkg::axiDataW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);
	import wiscPkg::*;

	// host side
	hostWriteT hostWr;
	logic [regIdxW-1:0] regRaddr;
	logic [dataW-1:0] regRdata;
	logic [dataW-1:0] pcVal;
	logic [statusW-1:0] statusBits;
	logic launch;
	logic [dataW-1:0] instrWord;
	// instruction path
	logic [regIdxW-1:0] rsIdx;
	logic [dataW-1:0] rsVal;
	logic decValid;
	decodedT dec;
	logic exValid;
	resultT res;

	axiLiteSlave iSlave (
		.clk(clk),
		.arstN(arstN),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.regRdata(regRdata),
		.pcVal(pcVal),
		.statusBits(statusBits),
		.hostWr(hostWr),
		.regRaddr(regRaddr),
		.launch(launch),
		.instrWord(instrWord)
	);

	instrDecode iDecode (
		.clk(clk),
		.arstN(arstN),
		.launch(launch),
		.instrWord(instrWord),
		.rsVal(rsVal),
		.pcVal(pcVal),
		.rsIdx(rsIdx),
		.decValid(decValid),
		.dec(dec)
	);

	branchJumpAlu iExec (
		.clk(clk),
		.arstN(arstN),
		.decValid(decValid),
		.dec(dec),
		.exValid(exValid),
		.res(res)
	);

	writeBack iWb (
		.clk(clk),
		.arstN(arstN),
		.hostWr(hostWr),
		.regRaddr(regRaddr),
		.rsIdx(rsIdx),
		.launch(launch),
		.exValid(exValid),
		.res(res),
		.regRdata(regRdata),
		.rsVal(rsVal),
		.pcVal(pcVal),
		.statusBits(statusBits)
	);

endmodule

//--- axiLiteSlave.sv
`timescale 1ns/1ps
module axiLiteSlave (
	input logic clk,
	input logic arstN,
	input logic [wiscPkg::axiAddrW-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [wiscPkg::axiDataW-1:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [wiscPkg::axiAddrW-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [wiscPkg::axiDataW-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic [wiscPkg::dataW-1:0] regRdata,
	input logic [wiscPkg::dataW-1:0] pcVal,
	input logic [wiscPkg::statusW-1:0] statusBits,
	output wiscPkg::hostWriteT hostWr,
	output logic [wiscPkg::regIdxW-1:0] regRaddr,
	output logic launch,
	output logic [wiscPkg::dataW-1:0] instrWord
);
	import wiscPkg::*;

	logic wrReady;
	logic wrStart;
	logic wrFire;
	logic wrIsReg;
	logic wrIsPc;
	logic wrIsInstr;
	logic wrOk;
	logic hostWrValid;
	logic [regIdxW:0] hostTarget;
	logic [dataW-1:0] hostData;
	logic rdFire;
	logic rdIsReg;
	logic [axiDataW-1:0] rdNext;
	logic [1:0] rdRespNext;

	// write decode, both low byte lanes must be enabled
	assign wrIsReg = (awaddr[axiAddrW-1:regSpanLsb] == regBase[axiAddrW-1:regSpanLsb])
		&& (awaddr[1:0] == 2'b00);
	assign wrIsPc = (awaddr == pcAddr);
	assign wrIsInstr = (awaddr == instrAddr);
	assign wrOk = (wrIsReg | wrIsPc | wrIsInstr) & (&wstrb[1:0]);

	// accept only when idle and no response or launch in flight
	assign wrStart = awvalid & wvalid & ~wrReady & ~bvalid & ~launch
		& ~statusBits[busyBit];
	assign wrFire = wrReady & awvalid & wvalid;
	assign awready = wrReady;
	assign wready = wrReady;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrReady <= 1'b0;
			bvalid <= 1'b0;
			hostWrValid <= 1'b0;
			launch <= 1'b0;
		end else begin
			wrReady <= wrStart;
			hostWrValid <= wrFire & wrOk & (wrIsReg | wrIsPc);
			// one-cycle launch pulse
			launch <= wrFire & wrOk & wrIsInstr;
			if (wrFire) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	// write payload, status writes fall into SLVERR
	always_ff @(posedge clk) begin
		if (wrFire) begin
			bresp <= wrOk ? respOkay : respSlvErr;
			hostTarget <= wrIsPc ? targetPc : {1'b0, awaddr[regSpanLsb-1:2]};
			hostData <= wdata[dataW-1:0];
			if (wrIsInstr) begin
				instrWord <= wdata[dataW-1:0];
			end
		end
	end

	assign hostWr = '{valid: hostWrValid, target: hostTarget, data: hostData};

	// read side
	assign arready = ~rvalid;
	assign rdFire = arvalid & arready;
	assign regRaddr = araddr[regSpanLsb-1:2];
	assign rdIsReg = (araddr[axiAddrW-1:regSpanLsb] == regBase[axiAddrW-1:regSpanLsb])
		&& (araddr[1:0] == 2'b00);

	always_comb begin
		rdNext = '0;
		rdRespNext = respOkay;
		if (rdIsReg) begin
			rdNext = axiDataW'(regRdata);
		end else if (araddr == pcAddr) begin
			rdNext = axiDataW'(pcVal);
		end else if (araddr == statusAddr) begin
			rdNext = axiDataW'(statusBits);
		end else begin
			// instrAddr is write only
			rdRespNext = respSlvErr;
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			rvalid <= 1'b0;
		end else if (rdFire) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rdFire) begin
			rdata <= rdNext;
			rresp <= rdRespNext;
		end
	end

endmodule

//--- writeBack.sv
`timescale 1ns/1ps
module writeBack (
	input logic clk,
	input logic arstN,
	input wiscPkg::hostWriteT hostWr,
	input logic [wiscPkg::regIdxW-1:0] regRaddr,
	input logic [wiscPkg::regIdxW-1:0] rsIdx,
	input logic launch,
	input logic exValid,
	input wiscPkg::resultT res,
	output logic [wiscPkg::dataW-1:0] regRdata,
	output logic [wiscPkg::dataW-1:0] rsVal,
	output logic [wiscPkg::dataW-1:0] pcVal,
	output logic [wiscPkg::statusW-1:0] statusBits
);
	import wiscPkg::*;

	logic [dataW-1:0] regFile [regCount];
	logic [dataW-1:0] pc;
	logic busy;
	logic ovfFlag;
	logic illegalFlag;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < regCount; i++) begin
				regFile[i] <= '0;
			end
			pc <= '0;
			busy <= 1'b0;
			ovfFlag <= 1'b0;
			illegalFlag <= 1'b0;
		end else begin
			// busy spans launch to commit
			if (launch) begin
				busy <= 1'b1;
			end
			// commit of the executed instruction
			if (exValid) begin
				busy <= 1'b0;
				ovfFlag <= res.ovf;
				illegalFlag <= res.illegal;
				if (res.writeEn) begin
					regFile[res.writeIdx] <= res.writeData;
				end
				// illegal opcodes leave the pc alone
				if (!res.illegal) begin
					pc <= res.newPc;
				end
			end
			// host writes only arrive while idle, flags untouched
			if (hostWr.valid) begin
				if (hostWr.target == targetPc) begin
					pc <= hostWr.data;
				end else begin
					regFile[hostWr.target[regIdxW-1:0]] <= hostWr.data;
				end
			end
		end
	end

	// read ports
	assign regRdata = regFile[regRaddr];
	assign rsVal = regFile[rsIdx];
	assign pcVal = pc;

	always_comb begin
		statusBits = '0;
		statusBits[busyBit] = busy;
		statusBits[ovfBit] = ovfFlag;
		statusBits[illegalBit] = illegalFlag;
	end

endmodule

//--- branchJumpAlu.sv
`timescale 1ns/1ps
module branchJumpAlu (
	input logic clk,
	input logic arstN,
	input logic decValid,
	input wiscPkg::decodedT dec,
	output logic exValid,
	output wiscPkg::resultT res
);
	import wiscPkg::*;

	logic [dataW-1:0] seqPc;
	logic [dataW-1:0] brTarget;
	logic [dataW-1:0] jmpTarget;
	logic seqOvf;
	logic brOvf;
	logic jmpOvf;
	logic taken;
	resultT resNext;

	// sequential pc
	cla16 iSeqAdd (
		.a(dec.curPc),
		.b(16'h0002),
		.cIn(1'b0),
		.sum(seqPc),
		.cOut(),
		.ovf(seqOvf)
	);

	// branch target relative to the sequential pc
	cla16 iBrAdd (
		.a(seqPc),
		.b(dec.imm),
		.cIn(1'b0),
		.sum(brTarget),
		.cOut(),
		.ovf(brOvf)
	);

	// jump target from rs
	cla16 iJmpAdd (
		.a(dec.rsVal),
		.b(dec.imm),
		.cIn(1'b0),
		.sum(jmpTarget),
		.cOut(),
		.ovf(jmpOvf)
	);

	// branch condition on rs
	always_comb begin
		case (dec.opcode)
			opBeqz: taken = (dec.rsVal == '0);
			opBnez: taken = (dec.rsVal != '0);
			opBltz: taken = dec.rsVal[dataW-1];
			opBgez: taken = ~dec.rsVal[dataW-1];
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		// default is a plain fall-through with no register write
		resNext.newPc = seqPc;
		resNext.writeData = dec.imm;
		resNext.writeEn = 1'b0;
		resNext.writeIdx = dec.rsIdx;
		resNext.ovf = seqOvf;
		resNext.illegal = 1'b0;
		case (dec.opcode)
			opBeqz, opBnez, opBltz, opBgez: begin
				resNext.newPc = taken ? brTarget : seqPc;
				resNext.ovf = taken ? brOvf : seqOvf;
			end
			opJr: begin
				resNext.newPc = jmpTarget;
				resNext.ovf = jmpOvf;
			end
			opJalr: begin
				resNext.newPc = jmpTarget;
				resNext.ovf = jmpOvf;
				// link to R7
				resNext.writeData = seqPc;
				resNext.writeEn = 1'b1;
				resNext.writeIdx = r7Idx;
			end
			opLbi: begin
				resNext.writeEn = 1'b1;
			end
			opSlbi: begin
				// shift by eight is just wiring
				resNext.writeData = {dec.rsVal[dataW-immW-1:0], dec.imm[immW-1:0]};
				resNext.writeEn = 1'b1;
			end
			default: begin
				// illegal keeps the pc and reports no overflow
				resNext.newPc = dec.curPc;
				resNext.ovf = 1'b0;
				resNext.illegal = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exValid <= 1'b0;
		end else begin
			exValid <= decValid;
		end
	end

	always_ff @(posedge clk) begin
		if (decValid) begin
			res <= resNext;
		end
	end

endmodule

//--- instrDecode.sv
`timescale 1ns/1ps
module instrDecode (
	input logic clk,
	input logic arstN,
	input logic launch,
	input logic [wiscPkg::dataW-1:0] instrWord,
	input logic [wiscPkg::dataW-1:0] rsVal,
	input logic [wiscPkg::dataW-1:0] pcVal,
	output logic [wiscPkg::regIdxW-1:0] rsIdx,
	output logic decValid,
	output wiscPkg::decodedT dec
);
	import wiscPkg::*;

	opcodeT opcode;
	logic [dataW-1:0] immSext;
	logic [dataW-1:0] immZext;
	decodedT decNext;

	// rs index goes straight to the register file read port
	assign rsIdx = instrWord[10:8];

	// anything outside the supported set is illegal
	always_comb begin
		case (instrWord[15:11])
			opBeqz, opBnez, opBltz, opBgez, opJr, opJalr, opLbi, opSlbi:
				opcode = opcodeT'(instrWord[15:11]);
			default:
				opcode = opIllegal;
		endcase
	end

	assign immSext = {{(dataW-immW){instrWord[immW-1]}}, instrWord[immW-1:0]};
	assign immZext = {{(dataW-immW){1'b0}}, instrWord[immW-1:0]};

	always_comb begin
		decNext.opcode = opcode;
		decNext.rsIdx = rsIdx;
		// only SLBI wants the raw byte
		decNext.imm = (opcode == opSlbi) ? immZext : immSext;
		decNext.rsVal = rsVal;
		decNext.curPc = pcVal;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			decValid <= 1'b0;
		end else begin
			decValid <= launch;
		end
	end

	// operands are stable while launch is high
	always_ff @(posedge clk) begin
		if (launch) begin
			dec <= decNext;
		end
	end

endmodule

//--- cla16.sv
`timescale 1ns/1ps
module cla16 (
	input logic [wiscPkg::dataW-1:0] a,
	input logic [wiscPkg::dataW-1:0] b,
	input logic cIn,
	output logic [wiscPkg::dataW-1:0] sum,
	output logic cOut,
	output logic ovf
);
	import wiscPkg::*;

	// bit propagate and generate
	logic [dataW-1:0] p;
	logic [dataW-1:0] g;
	// group terms over four-bit slices
	logic [3:0] gp;
	logic [3:0] gg;
	// carry into each group, gc[4] is the final carry
	logic [4:0] gc;
	// carry into each bit
	logic [dataW:0] c;

	assign p = a ^ b;
	assign g = a & b;

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			gp[k] = &p[4*k +: 4];
			gg[k] = g[4*k+3] | (p[4*k+3] & g[4*k+2]) | (p[4*k+3] & p[4*k+2] & g[4*k+1])
				| (p[4*k+3] & p[4*k+2] & p[4*k+1] & g[4*k]);
		end
	end

	// second level lookahead across the groups
	assign gc[0] = cIn;
	assign gc[1] = gg[0] | (gp[0] & cIn);
	assign gc[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & cIn);
	assign gc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
		| (gp[2] & gp[1] & gp[0] & cIn);
	assign gc[4] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
		| (gp[3] & gp[2] & gp[1] & gg[0]) | (gp[3] & gp[2] & gp[1] & gp[0] & cIn);

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			c[4*k] = gc[k];
			// carries inside a group from its own carry-in
			for (int i = 0; i < 3; i++) begin
				c[4*k+i+1] = g[4*k+i] | (p[4*k+i] & c[4*k+i]);
			end
		end
		c[dataW] = gc[4];
	end

	assign sum = p ^ c[dataW-1:0];
	assign cOut = c[dataW];
	// signed overflow when carry into and out of the sign bit differ
	assign ovf = c[dataW-1] ^ c[dataW];

endmodule

//--- wiscPkg.sv
package wiscPkg;

	// datapath sizes fixed by the ISA
	localparam int dataW = 16;
	localparam int regCount = 8;
	localparam int regIdxW = 3;
	localparam int immW = 8;

	// AXI4-Lite bus widths
	localparam int axiAddrW = 8;
	localparam int axiDataW = 32;

	// register map, one 32-bit word per slot
	localparam logic [axiAddrW-1:0] regBase = 8'h00;
	localparam logic [axiAddrW-1:0] pcAddr = 8'h20;
	localparam logic [axiAddrW-1:0] instrAddr = 8'h24;
	localparam logic [axiAddrW-1:0] statusAddr = 8'h28;
	// first address bit above the register window
	localparam int regSpanLsb = $clog2(regCount) + 2;

	// response codes
	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// status word bits
	localparam int statusW = 3;
	localparam int busyBit = 0;
	localparam int ovfBit = 1;
	localparam int illegalBit = 2;

	// link register for JALR
	localparam logic [regIdxW-1:0] r7Idx = 3'd7;
	// host write target with msb set selects the PC
	localparam logic [regIdxW:0] targetPc = 4'b1000;

	typedef enum logic [4:0] {
		opJr = 5'b00101,
		opJalr = 5'b00111,
		opBeqz = 5'b01100,
		opBnez = 5'b01101,
		opBltz = 5'b01110,
		opBgez = 5'b01111,
		opSlbi = 5'b10010,
		opLbi = 5'b11000,
		opIllegal = 5'b11111
	} opcodeT;

	// decode to execute
	typedef struct packed {
		opcodeT opcode;
		logic [regIdxW-1:0] rsIdx;
		logic [dataW-1:0] imm;
		logic [dataW-1:0] rsVal;
		logic [dataW-1:0] curPc;
	} decodedT;

	// execute to writeBack
	typedef struct packed {
		logic [dataW-1:0] newPc;
		logic [dataW-1:0] writeData;
		logic writeEn;
		logic [regIdxW-1:0] writeIdx;
		logic ovf;
		logic illegal;
	} resultT;

	// host register or PC write
	typedef struct packed {
		logic valid;
		logic [regIdxW:0] target;
		logic [dataW-1:0] data;
	} hostWriteT;

endpackage
